// ==== fetch_config.svh ====
/*
  Build-time configuration of the multithreaded fetch unit.
  FETCH_NUM_THREADS must be a power of two, and at least 2.
  FETCH_ALIGN_BITS must stay below FETCH_VLEN.
  FETCH_DEBUG_ADDR is used only while FETCH_DEBUG_EN is 1.
*/
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// hardware thread count
`define FETCH_NUM_THREADS 4

// virtual fetch address width
`define FETCH_VLEN 32

// low pc bits cleared on a sequential step
`define FETCH_ALIGN_BITS 2

// debug entry point, taken when the debug redirect is enabled
`define FETCH_DEBUG_ADDR 32'h0000_0800
`define FETCH_DEBUG_EN 1

`endif

// ==== fetch_pkg.sv ====
/*
  Address and pc-source types of the fetch unit.
  Widths follow the macros in the config header.
*/
`include "fetch_config.svh"

package fetch_pkg;

  // virtual fetch address
  typedef logic [`FETCH_VLEN-1:0] vaddr_t;

  // winning source of a pc write, in no particular priority order
  typedef enum logic [2:0] {
    NONE,
    SEQ,
    MISPREDICT,
    ERET,
    TRAP,
    COMMIT,
    DEBUG
  } pc_src_e;

endpackage

// ==== thread_pkg.sv ====
/*
  Thread id and thread status types.
  The id width is derived from the thread count in the config header.
*/
`include "fetch_config.svh"

package thread_pkg;

  // index of a hardware thread
  typedef logic [$clog2(`FETCH_NUM_THREADS)-1:0] thread_id_t;

  // a thread waits in STALLED_ICACHE until its miss returns
  typedef enum logic {
    READY,
    STALLED_ICACHE
  } thread_status_e;

  // one status entry per thread, indexed by thread id
  typedef thread_status_e [`FETCH_NUM_THREADS-1:0] thread_status_vec_t;

endpackage

// ==== thread_context.sv ====
/*
  Per-thread pc and status storage.
  One pc write port and one status write port, both take effect next cycle.
  The pc read is combinational. Reset loads boot_addr_i into every pc,
  so boot_addr_i must be stable while rst_ni is low.
*/
`include "fetch_config.svh"

module thread_context
  import fetch_pkg::*;
  import thread_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vaddr_t             boot_addr_i,
  // pc read, current thread
  input  thread_id_t         rd_tid_i,
  output vaddr_t             rd_pc_o,
  // pc write
  input  logic               pc_we_i,
  input  thread_id_t         pc_wtid_i,
  input  vaddr_t             pc_wdata_i,
  // status write
  input  logic               st_we_i,
  input  thread_id_t         st_wtid_i,
  input  thread_status_e     st_wdata_i,
  output thread_status_vec_t status_o
);

  vaddr_t             pc_q [`FETCH_NUM_THREADS];
  thread_status_vec_t status_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `FETCH_NUM_THREADS; i++) begin
        pc_q[i]     <= boot_addr_i;
        status_q[i] <= READY;
      end
    end else begin
      if (pc_we_i) begin
        pc_q[pc_wtid_i] <= pc_wdata_i;
      end
      if (st_we_i) begin
        status_q[st_wtid_i] <= st_wdata_i;
      end
    end
  end

  assign rd_pc_o  = pc_q[rd_tid_i];
  assign status_o = status_q;

endmodule

// ==== thread_scheduler.sv ====
/*
  Round-robin thread selection and single icache miss tracking.
  Only one miss is outstanding at a time; a second miss waits until
  the first one returns. Rotation skips every thread not READY.
*/
`include "fetch_config.svh"

module thread_scheduler
  import thread_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               fetch_ready_i,
  input  logic               halt_i,
  input  logic               flush_i,
  input  logic               icache_ready_i,
  input  logic               icache_ex_i,
  input  thread_status_vec_t status_i,
  output thread_id_t         cur_tid_o,
  output logic               stall_pending_o,
  // status write towards the context
  output logic               st_we_o,
  output thread_id_t         st_wtid_o,
  output thread_status_e     st_wdata_o
);

  thread_id_t cur_tid_q, cur_tid_d;
  thread_id_t stall_tid_q, stall_tid_d;
  logic       pending_q, pending_d;
  thread_id_t cand;
  logic       found;

  // ------------------------------------------------------------
  // round robin
  // ------------------------------------------------------------
  // nearest READY thread after the current one wins
  always_comb begin
    cur_tid_d = cur_tid_q;
    found     = 1'b0;
    cand      = cur_tid_q;
    if (fetch_ready_i && !halt_i) begin
      for (int i = 1; i < `FETCH_NUM_THREADS; i++) begin
        cand = thread_id_t'((int'(cur_tid_q) + i) % `FETCH_NUM_THREADS);
        if (!found && status_i[cand] == READY) begin
          cur_tid_d = cand;
          found     = 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // miss tracker
  // ------------------------------------------------------------
  always_comb begin
    st_we_o     = 1'b0;
    st_wtid_o   = cur_tid_q;
    st_wdata_o  = READY;
    pending_d   = pending_q;
    stall_tid_d = stall_tid_q;

    // cache refused the request, park the current thread
    if (fetch_ready_i && !icache_ready_i && status_i[cur_tid_q] == READY && !pending_q) begin
      st_we_o     = 1'b1;
      st_wdata_o  = STALLED_ICACHE;
      pending_d   = 1'b1;
      stall_tid_d = cur_tid_q;
    end

    // miss returned; a faulting thread stays parked
    if (pending_q && icache_ready_i) begin
      pending_d = 1'b0;
      if (!icache_ex_i) begin
        st_we_o   = 1'b1;
        st_wtid_o = stall_tid_q;
      end
    end

    if (flush_i) begin
      pending_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_tid_q   <= '0;
      stall_tid_q <= '0;
      pending_q   <= 1'b0;
    end else begin
      cur_tid_q   <= cur_tid_d;
      stall_tid_q <= stall_tid_d;
      pending_q   <= pending_d;
    end
  end

  assign cur_tid_o       = cur_tid_q;
  assign stall_pending_o = pending_q;

endmodule

// ==== next_pc_select.sv ====
/*
  Picks at most one pc write per cycle.
  Priority: sequential, mispredict, eret, trap, commit; debug overrides all.
  Lower-priority redirects in the same cycle are dropped, so the
  issuing side must hold them until they are taken.
*/
`include "fetch_config.svh"

module next_pc_select
  import fetch_pkg::*;
  import thread_pkg::*;
(
  input  logic       icache_req_i,
  input  logic       icache_ready_i,
  input  thread_id_t cur_tid_i,
  input  vaddr_t     cur_pc_i,
  input  logic       halt_i,
  input  logic       mispredict_i,
  input  thread_id_t mispredict_tid_i,
  input  vaddr_t     mispredict_addr_i,
  input  logic       eret_i,
  input  thread_id_t eret_tid_i,
  input  vaddr_t     epc_i,
  input  logic       ex_valid_i,
  input  thread_id_t ex_tid_i,
  input  vaddr_t     trap_vector_i,
  input  logic       set_pc_commit_i,
  input  thread_id_t commit_tid_i,
  input  vaddr_t     pc_commit_i,
  input  logic       set_debug_pc_i,
  input  thread_id_t debug_tid_i,
  output logic       pc_we_o,
  output thread_id_t pc_wtid_o,
  output vaddr_t     pc_wdata_o
);

  pc_src_e src;
  vaddr_t  seq_pc;
  vaddr_t  commit_pc;

  assign seq_pc = {cur_pc_i[`FETCH_VLEN-1:`FETCH_ALIGN_BITS], {`FETCH_ALIGN_BITS{1'b0}}}
                + vaddr_t'(4);
  // a halted core restarts on the committed instruction itself
  assign commit_pc = halt_i ? pc_commit_i : pc_commit_i + vaddr_t'(4);

  always_comb begin
    src = NONE;
    if (icache_req_i && icache_ready_i) src = SEQ;
    else if (mispredict_i) src = MISPREDICT;
    else if (eret_i) src = ERET;
    else if (ex_valid_i) src = TRAP;
    else if (set_pc_commit_i) src = COMMIT;
    if ((`FETCH_DEBUG_EN != 0) && set_debug_pc_i) src = DEBUG;
  end

  always_comb begin
    pc_we_o    = (src != NONE);
    pc_wtid_o  = cur_tid_i;
    pc_wdata_o = seq_pc;
    case (src)
      MISPREDICT: begin
        pc_wtid_o  = mispredict_tid_i;
        pc_wdata_o = mispredict_addr_i;
      end
      ERET: begin
        pc_wtid_o  = eret_tid_i;
        pc_wdata_o = epc_i;
      end
      TRAP: begin
        pc_wtid_o  = ex_tid_i;
        pc_wdata_o = trap_vector_i;
      end
      COMMIT: begin
        pc_wtid_o  = commit_tid_i;
        pc_wdata_o = commit_pc;
      end
      DEBUG: begin
        pc_wtid_o  = debug_tid_i;
        pc_wdata_o = vaddr_t'(`FETCH_DEBUG_ADDR);
      end
      default: ;
    endcase
  end

endmodule

// ==== mt_fetch_frontend.sv ====
/*
  Multithreaded fetch pc unit with a plain request strobe to the icache.
  A fetch is accepted when icache_req_o and icache_ready_i are both high.
  No request is issued while an icache miss is pending.
*/
module mt_fetch_frontend
  import fetch_pkg::*;
  import thread_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  vaddr_t     boot_addr_i,
  input  logic       halt_i,
  input  logic       flush_i,
  input  logic       fetch_ready_i,
  input  logic       icache_ready_i,
  input  logic       icache_ex_i,
  // redirects, each tagged with its thread
  input  logic       mispredict_i,
  input  thread_id_t mispredict_tid_i,
  input  vaddr_t     mispredict_addr_i,
  input  logic       eret_i,
  input  thread_id_t eret_tid_i,
  input  vaddr_t     epc_i,
  input  logic       ex_valid_i,
  input  thread_id_t ex_tid_i,
  input  vaddr_t     trap_vector_i,
  input  logic       set_pc_commit_i,
  input  thread_id_t commit_tid_i,
  input  vaddr_t     pc_commit_i,
  input  logic       set_debug_pc_i,
  input  thread_id_t debug_tid_i,
  // icache request
  output logic       icache_req_o,
  output vaddr_t     icache_vaddr_o,
  output thread_id_t icache_tid_o
);

  thread_id_t         cur_tid;
  vaddr_t             cur_pc;
  thread_status_vec_t status;
  logic               stall_pending;
  logic               st_we;
  thread_id_t         st_wtid;
  thread_status_e     st_wdata;
  logic               pc_we;
  thread_id_t         pc_wtid;
  vaddr_t             pc_wdata;

  assign icache_req_o   = fetch_ready_i & ~stall_pending;
  assign icache_vaddr_o = cur_pc;
  assign icache_tid_o   = cur_tid;

  thread_context i_thread_context (
    .clk_i, .rst_ni, .boot_addr_i,
    .rd_tid_i   (cur_tid),
    .rd_pc_o    (cur_pc),
    .pc_we_i    (pc_we),
    .pc_wtid_i  (pc_wtid),
    .pc_wdata_i (pc_wdata),
    .st_we_i    (st_we),
    .st_wtid_i  (st_wtid),
    .st_wdata_i (st_wdata),
    .status_o   (status)
  );

  thread_scheduler i_thread_scheduler (
    .clk_i, .rst_ni, .fetch_ready_i, .halt_i, .flush_i, .icache_ready_i, .icache_ex_i,
    .status_i        (status),
    .cur_tid_o       (cur_tid),
    .stall_pending_o (stall_pending),
    .st_we_o         (st_we),
    .st_wtid_o       (st_wtid),
    .st_wdata_o      (st_wdata)
  );

  // redirect inputs connect by name
  next_pc_select i_next_pc_select (
    .icache_req_i (icache_req_o),
    .cur_tid_i    (cur_tid),
    .cur_pc_i     (cur_pc),
    .pc_we_o      (pc_we),
    .pc_wtid_o    (pc_wtid),
    .pc_wdata_o   (pc_wdata),
    .*
  );

endmodule

// ==== mt_fetch_assertions.sv ====
/*
  Concurrent checks on the icache request port of the fetch unit.
  Bound into every instance of the top level.
*/
module mt_fetch_assertions
  import fetch_pkg::*;
  import thread_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input vaddr_t     boot_addr_i,
  input logic       fetch_ready_i,
  input logic       halt_i,
  input logic       icache_req_i,
  input vaddr_t     icache_vaddr_i,
  input thread_id_t icache_tid_i
);

  // failed assertions so far
  int fail_count = 0;

  // no request under back-pressure
  req_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_ready_i |-> !icache_req_i)
    else begin
      fail_count++;
      $error("icache request raised while fetch_ready_i is low");
    end

  // a halted core keeps its current thread
  tid_held_on_halt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(halt_i) |-> $stable(icache_tid_i))
    else begin
      fail_count++;
      $error("current thread changed while halt_i was high");
    end

  // first cycle out of reset fetches from the boot address
  boot_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> icache_vaddr_i == boot_addr_i)
    else begin
      fail_count++;
      $error("fetch address differs from boot_addr_i after reset");
    end

endmodule

bind mt_fetch_frontend mt_fetch_assertions u_fetch_assertions (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .boot_addr_i    (boot_addr_i),
  .fetch_ready_i  (fetch_ready_i),
  .halt_i         (halt_i),
  .icache_req_i   (icache_req_o),
  .icache_vaddr_i (icache_vaddr_o),
  .icache_tid_i   (icache_tid_o)
);

// ==== tb_mt_fetch_frontend.sv ====
/*
  Testbench for the multithreaded fetch unit, driven from fetch_patterns.txt.
  Each pattern line is one clock cycle. Inputs change on the falling edge,
  outputs are checked a quarter period later, before the next rising edge.
  Run from the project root so that the pattern file is found.
*/
module tb_mt_fetch_frontend
  import fetch_pkg::*;
  import thread_pkg::*;
();

  localparam int PERIOD = 100;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  vaddr_t     boot_addr_i;
  logic       halt_i, flush_i, fetch_ready_i, icache_ready_i, icache_ex_i;
  logic       mispredict_i, eret_i, ex_valid_i, set_pc_commit_i, set_debug_pc_i;
  thread_id_t mispredict_tid_i, eret_tid_i, ex_tid_i, commit_tid_i, debug_tid_i;
  vaddr_t     mispredict_addr_i, epc_i, trap_vector_i, pc_commit_i;
  logic       icache_req_o;
  vaddr_t     icache_vaddr_o;
  thread_id_t icache_tid_o;

  vaddr_t     exp_vaddr;
  thread_id_t exp_tid;
  logic       exp_req;

  string patterns[$];
  int    step;
  int    check_count = 0;
  int    mismatch_count = 0;
  int    other_errors = 0;
  int    cycle_count = 0;
  int    cycle_limit = 20;

  mt_fetch_frontend dut (.*);

  always #(PERIOD / 2) clk_i = ~clk_i;

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic clear_inputs();
    boot_addr_i = 32'h0000_1000;
    {halt_i, flush_i, fetch_ready_i, icache_ready_i, icache_ex_i} = '0;
    {mispredict_i, eret_i, ex_valid_i, set_pc_commit_i, set_debug_pc_i} = '0;
    {mispredict_tid_i, eret_tid_i, ex_tid_i, commit_tid_i, debug_tid_i} = '0;
    {mispredict_addr_i, epc_i, trap_vector_i, pc_commit_i} = '0;
  endtask

  // comment lines start with # and are skipped
  task automatic load_patterns();
    int    fd;
    string line;
    fd = $fopen("fetch_patterns.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the pattern file fetch_patterns.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") patterns.push_back(line);
      end
      $fclose(fd);
    end
    if (patterns.size() == 0) begin
      other_errors++;
      $display("the pattern file holds no patterns");
    end
  endtask

  task automatic apply_pattern(input string line, output bit ok);
    int n;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                halt_i, flush_i, fetch_ready_i, icache_ready_i, icache_ex_i,
                mispredict_i, mispredict_tid_i, mispredict_addr_i,
                eret_i, eret_tid_i, epc_i, ex_valid_i, ex_tid_i, trap_vector_i,
                set_pc_commit_i, commit_tid_i, pc_commit_i, set_debug_pc_i, debug_tid_i,
                exp_vaddr, exp_tid, exp_req);
    ok = (n == 22);
    if (!ok) begin
      other_errors++;
      $display("pattern %0d is malformed, only %0d of 22 fields were read", step, n);
    end
  endtask

  // ------------------------------------------------------------
  // compare
  // ------------------------------------------------------------
  task automatic check_vaddr(input string name, input vaddr_t got, input vaddr_t exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s step %0d: got %h expected %h", name, step, got, exp);
    end
  endtask

  task automatic check_tid(input string name, input thread_id_t got, input thread_id_t exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s step %0d: got %h expected %h", name, step, got, exp);
    end
  endtask

  task automatic check_req(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s step %0d: got %h expected %h", name, step, got, exp);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    bit ok;
    clear_inputs();
    rst_ni = 1'b0;
    load_patterns();
    cycle_limit = 2 * patterns.size() + 20;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (patterns[i]) begin
      step = i + 1;
      apply_pattern(patterns[i], ok);
      #(PERIOD / 4);
      if (ok) begin
        check_vaddr("icache_vaddr_o", icache_vaddr_o, exp_vaddr);
        check_tid("icache_tid_o", icache_tid_o, exp_tid);
        check_req("icache_req_o", icache_req_o, exp_req);
      end
      @(negedge clk_i);
    end
    $display("checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
             check_count, mismatch_count, other_errors,
             dut.u_fetch_assertions.fail_count);
    if (mismatch_count == 0 && other_errors == 0 &&
        dut.u_fetch_assertions.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== fetch_patterns.txt ====
# halt flush fetch_rdy ic_rdy ic_ex mis mis_tid mis_addr eret eret_tid epc ex ex_tid trap_vec
# commit commit_tid pc_commit dbg dbg_tid, then expected vaddr tid req; hex, one cycle per line
0 0 0 0 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001000 0 0
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001000 0 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001000 1 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001000 2 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001000 3 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001004 0 1
0 0 0 1 0 1 2 00002000 1 3 00003000 1 0 00004000 1 1 00005000 0 0 00001004 1 0
0 0 0 1 0 0 0 00000000 0 0 00000000 0 0 00000000 1 1 00005000 0 0 00001004 1 0
1 0 0 1 0 0 0 00000000 0 0 00000000 0 0 00000000 1 1 00006000 0 0 00005004 1 0
0 0 0 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00006000 1 0
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00006000 1 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00002000 2 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001004 3 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001008 0 1
0 0 1 0 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00006004 1 1
0 0 1 0 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00002004 2 0
0 0 1 0 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001008 3 0
0 0 1 0 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 0000100c 0 0
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00002004 2 0
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001008 3 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 0000100c 0 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00006004 1 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00002004 2 1
0 0 1 0 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 0000100c 3 1
0 0 1 1 1 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001010 0 0
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00006008 1 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00002008 2 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 1 2 00001010 0 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 0000600c 1 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000800 2 1
0 0 1 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00001010 0 1
0 0 0 1 0 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00000000 0 0 00006010 1 0

// ==== vlog.f ====
+incdir+.
fetch_pkg.sv
thread_pkg.sv
thread_context.sv
thread_scheduler.sv
next_pc_select.sv
mt_fetch_frontend.sv
mt_fetch_assertions.sv
tb_mt_fetch_frontend.sv

// ==== Bender.yml ====
package:
  name: mt_fetch_frontend

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - thread_pkg.sv
      - thread_context.sv
      - thread_scheduler.sv
      - next_pc_select.sv
      - mt_fetch_frontend.sv

  - target: test
    files:
      - mt_fetch_assertions.sv
      - tb_mt_fetch_frontend.sv
